// ==== dv/exmem_golden.txt ====
// stall ctrl alu_op operand_a operand_b store_data dest link | wb_we wb_dest wb_data jump target
// ctrl bits 5..0: mem_read mem_write reg_write mem_to_reg link_sel jump; expected is next cycle
0 08 0 00000005 00000007 00000000 01 00000000  1 01 0000000c 0 0000000c
0 08 1 00000003 00000005 00000000 02 00000000  1 02 fffffffe 0 fffffffe
0 08 2 f0f0f0f0 ff00ff00 00000000 03 00000000  1 03 f000f000 0 f000f000
0 08 3 f0f0f0f0 0f0f0000 00000000 04 00000000  1 04 fffff0f0 0 fffff0f0
0 08 4 12345678 ffffffff 00000000 05 00000000  1 05 edcba987 0 edcba987
0 08 5 0000ff00 00ff0000 00000000 06 00000000  1 06 ff0000ff 0 ff0000ff
0 08 6 ffffffff 00000001 00000000 07 00000000  1 07 00000001 0 00000001
0 08 7 ffffffff 00000001 00000000 08 00000000  1 08 00000000 0 00000000
0 08 8 00000024 00000003 00000000 09 00000000  1 09 00000030 0 00000030
0 08 9 00000008 80000000 00000000 0a 00000000  1 0a 00800000 0 00800000
0 08 a 00000008 80000000 00000000 0b 00000000  1 0b ff800000 0 ff800000
0 08 b 00000000 1234abcd 00000000 0c 00000000  1 0c abcd0000 0 abcd0000
0 08 c 00000040 00000000 00000000 0d 00000000  1 0d 00000040 0 00000040
0 10 0 00000100 00000010 cafef00d 00 00000000  0 00 00000110 0 00000110
0 10 0 00000000 00000024 13579bdf 00 00000000  0 00 00000024 0 00000024
0 2c 0 00000000 00000010 00000000 0e 00000000  1 0e cafef00d 0 00000010
0 2c 0 00000020 00000004 00000000 0f 00000000  1 0f 13579bdf 0 00000024
0 0f 0 00400000 00000100 00000000 1f 00000208  1 1f 00000208 1 00400100
0 01 c 00001000 00000000 00000000 00 00000000  0 00 00001000 1 00001000
0 08 0 00000001 00000001 00000000 02 00000000  1 02 00000002 0 00000002
1 08 0 00000077 00000000 00000000 03 00000000  1 02 00000002 0 00000002
1 01 c 00002000 00000000 00000000 00 00000000  1 02 00000002 0 00000002
0 08 0 00000100 00000023 00000000 04 00000000  1 04 00000123 0 00000123
0 10 0 00000000 00000030 0badc0de 00 00000000  0 00 00000030 0 00000030
1 10 0 00000000 00000034 deadbeef 00 00000000  0 00 00000030 0 00000030
0 2c 0 00000000 00000030 00000000 05 00000000  1 05 0badc0de 0 00000030
ffffffff 0 0 0 0 0 0 0  0 0 0 0 0

// ==== vlog.f ====
source/exmem_pkg.sv
source/execute_stage.sv
source/ex_mem_reg.sv
source/memory_stage.sv
source/exmem_top.sv
dv/tb_clock_gen.sv
dv/tb_exmem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_exmem -f vlog.f || exit 1

sim_output="$(./obj_dir/Vtb_exmem)"
echo "$sim_output"

echo "$sim_output" | grep -qx "SIMULATION PASSED" && exit 0 || exit 1

// ==== dv/tb_exmem.sv ====
// Testbench for the execute-to-memory slice; replays golden vectors and checks o_wb and jump outputs
`timescale 1ns/1ps

module tb_exmem;

    localparam int         FIELDS        = 13;           // Words per golden vector
    localparam int         MAX_VECTORS   = 64;
    localparam int         RESET_TIMEOUT = 32;           // Cycles
    localparam logic[31:0] END_MARKER    = 32'hffff_ffff;

    logic                 clk;
    logic                 reset;
    logic                 stall;
    exmem_pkg::ex_ctrl_t  ctrl;
    exmem_pkg::alu_op_t   alu_op;
    exmem_pkg::word_t     operand_a;
    exmem_pkg::word_t     operand_b;
    exmem_pkg::word_t     store_data;
    exmem_pkg::reg_addr_t dest_reg;
    exmem_pkg::word_t     link_addr;
    exmem_pkg::wb_t       wb;
    logic                 jump;
    exmem_pkg::word_t     jump_target;

    logic [31:0] golden_mem [0:1023];                    // Flat list of vector fields
    int          error_count;
    int          check_count;
    int          vector_count;
    logic        golden_ok;
    logic        reset_ok;

    tb_clock_gen u_clock_gen
    (
        .o_clk   (clk),
        .o_reset (reset)
    );

    exmem_top u_dut
    (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_stall       (stall),
        .i_ctrl        (ctrl),
        .i_alu_op      (alu_op),
        .i_operand_a   (operand_a),
        .i_operand_b   (operand_b),
        .i_store_data  (store_data),
        .i_dest_reg    (dest_reg),
        .i_link_addr   (link_addr),
        .o_wb          (wb),
        .o_jump        (jump),
        .o_jump_target (jump_target)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // Counts vectors up to the end marker line
    task automatic load_golden(output int count, output logic found);
        logic [9:0] base;
        int         scanned;
        $readmemh("dv/exmem_golden.txt", golden_mem);
        base    = '0;
        count   = 0;
        found   = 1'b0;
        scanned = 0;
        while (!found && scanned < MAX_VECTORS)
        begin
            if (golden_mem[base] === END_MARKER)
            begin
                found = 1'b1;
            end
            else
            begin
                count++;
                base = base + 10'(FIELDS);
            end
            scanned++;
        end
        if (!found)
        begin
            $display("Golden file has no end marker within %0d vectors", MAX_VECTORS);
        end
    endtask

    task automatic wait_reset_release(output logic released);
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (reset && cycles < RESET_TIMEOUT);
        released = !reset;
        if (!released)
        begin
            $display("Reset was still high after %0d cycles", RESET_TIMEOUT);
        end
    endtask

    task automatic drive_vector(input logic [9:0] base);
        stall      <= golden_mem[base][0];
        ctrl       <= golden_mem[base + 10'd1][5:0];
        alu_op     <= exmem_pkg::alu_op_t'(golden_mem[base + 10'd2][3:0]);
        operand_a  <= golden_mem[base + 10'd3];
        operand_b  <= golden_mem[base + 10'd4];
        store_data <= golden_mem[base + 10'd5];
        dest_reg   <= golden_mem[base + 10'd6][4:0];
        link_addr  <= golden_mem[base + 10'd7];
    endtask

    task automatic drive_idle();
        stall      <= 1'b0;
        ctrl       <= '0;                        // Bubble, nothing written
        alu_op     <= exmem_pkg::ALU_ADD;
        operand_a  <= '0;
        operand_b  <= '0;
        store_data <= '0;
        dest_reg   <= '0;
        link_addr  <= '0;
    endtask

    task automatic check_outputs(input logic [31:0] exp_reg_write, input logic [31:0] exp_dest,
                                 input logic [31:0] exp_data, input logic [31:0] exp_jump,
                                 input logic [31:0] exp_target);
        check_value("o_wb.reg_write", exp_reg_write, {31'd0, wb.reg_write});
        check_value("o_wb.dest_reg", exp_dest, {27'd0, wb.dest_reg});
        check_value("o_wb.data", exp_data, wb.data);
        check_value("o_jump", exp_jump, {31'd0, jump});
        check_value("o_jump_target", exp_target, jump_target);
    endtask

    // One vector per cycle; each is checked mid-cycle after the edge that registers it
    task automatic run_vectors(input int count);
        logic [9:0] base;
        logic [9:0] prev_base;
        int         k;
        base      = '0;
        prev_base = '0;
        for (k = 0; k <= count; k++)
        begin
            @(posedge clk);
            if (k < count)
            begin
                drive_vector(base);
            end
            else
            begin
                drive_idle();
            end
            @(negedge clk);
            if (k > 0)
            begin
                check_outputs(golden_mem[prev_base + 10'd8], golden_mem[prev_base + 10'd9],
                              golden_mem[prev_base + 10'd10], golden_mem[prev_base + 10'd11],
                              golden_mem[prev_base + 10'd12]);
            end
            prev_base = base;
            base      = base + 10'(FIELDS);
        end
    endtask

    initial
    begin
        error_count = 0;
        check_count = 0;
        stall       = 1'b0;
        ctrl        = 6'b001001;                 // reg_write and jump live during reset
        alu_op      = exmem_pkg::ALU_ADD;
        operand_a   = 32'h0000_1234;
        operand_b   = 32'h0000_0010;
        store_data  = '0;
        dest_reg    = 5'd7;
        link_addr   = 32'h0000_0100;
        load_golden(vector_count, golden_ok);
        wait_reset_release(reset_ok);
        if (!golden_ok || !reset_ok)
        begin
            $display("SIMULATION FAILED");
            $finish;
        end
        else
        begin
            check_outputs(32'd0, 32'd0, 32'd0, 32'd0, 32'd0);   // Cleared entry after reset
            run_vectors(vector_count);
            $display("Vectors %0d, checks %0d, errors %0d", vector_count, check_count,
                     error_count);
            if (error_count == 0)
            begin
                $display("SIMULATION PASSED");
            end
            else
            begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== dv/tb_clock_gen.sv ====
// Testbench clock and reset source; 40 ns clock with reset held high for the first 8 cycles
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic o_clk,
    output logic o_reset
);

    initial
    begin
        o_clk = 1'b0;
        forever
        begin
            #20 o_clk = ~o_clk;                  // Half of the 40 ns period
        end
    end

    initial
    begin
        o_reset = 1'b1;
        repeat (8) @(posedge o_clk);
        o_reset <= 1'b0;                         // Released on a rising edge
    end

endmodule

// ==== source/exmem_top.sv ====
// Top level of the execute-to-memory slice; connects execute, EX/MEM register and memory stage
`timescale 1ns/1ps

module exmem_top
(
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_stall,        // Holds the EX/MEM register
    input  exmem_pkg::ex_ctrl_t  i_ctrl,
    input  exmem_pkg::alu_op_t   i_alu_op,
    input  exmem_pkg::word_t     i_operand_a,
    input  exmem_pkg::word_t     i_operand_b,
    input  exmem_pkg::word_t     i_store_data,
    input  exmem_pkg::reg_addr_t i_dest_reg,
    input  exmem_pkg::word_t     i_link_addr,
    output exmem_pkg::wb_t       o_wb,
    output logic                 o_jump,
    output exmem_pkg::word_t     o_jump_target
);

    exmem_pkg::ex_mem_t ex_entry;                // Execute result, unregistered
    exmem_pkg::ex_mem_t mem_entry;               // Registered entry

    execute_stage u_execute
    (
        .i_ctrl       (i_ctrl),
        .i_alu_op     (i_alu_op),
        .i_operand_a  (i_operand_a),
        .i_operand_b  (i_operand_b),
        .i_store_data (i_store_data),
        .i_dest_reg   (i_dest_reg),
        .i_link_addr  (i_link_addr),
        .o_entry      (ex_entry)
    );

    ex_mem_reg u_ex_mem
    (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_stall (i_stall),
        .i_entry (ex_entry),
        .o_entry (mem_entry)
    );

    memory_stage u_memory
    (
        .i_clk         (i_clk),
        .i_entry       (mem_entry),
        .o_wb          (o_wb),
        .o_jump        (o_jump),
        .o_jump_target (o_jump_target)
    );

endmodule

// ==== source/memory_stage.sv ====
// Memory stage; word-addressed data memory access and write-back source selection
`timescale 1ns/1ps

module memory_stage
(
    input  logic               i_clk,
    input  exmem_pkg::ex_mem_t i_entry,          // Registered EX/MEM entry
    output exmem_pkg::wb_t     o_wb,             // Toward the register file
    output logic               o_jump,           // Jump request to fetch
    output exmem_pkg::word_t   o_jump_target
);

    exmem_pkg::word_t   dmem [exmem_pkg::DMEM_DEPTH];
    exmem_pkg::dmem_addr_t dmem_addr;
    exmem_pkg::word_t   load_data;
    exmem_pkg::word_t   wb_data;

    // Byte address to word index
    assign dmem_addr = i_entry.alu_result[exmem_pkg::DMEM_ADDR_W+1:2];

    always_ff @(posedge i_clk)
    begin
        if (i_entry.ctrl.mem_write)
        begin
            dmem[dmem_addr] <= i_entry.store_data;
        end
    end

    assign load_data = dmem[dmem_addr];          // Asynchronous read

    // Link address wins, then the loaded word, then the ALU result
    always_comb
    begin
        if (i_entry.ctrl.link_sel)
        begin
            wb_data = i_entry.link_addr;
        end
        else if (i_entry.ctrl.mem_to_reg)
        begin
            wb_data = load_data;
        end
        else
        begin
            wb_data = i_entry.alu_result;
        end
    end

    assign o_wb.reg_write = i_entry.ctrl.reg_write;
    assign o_wb.dest_reg  = i_entry.dest_reg;
    assign o_wb.data      = wb_data;

    // Target already resolved by the execute stage
    assign o_jump        = i_entry.ctrl.jump;
    assign o_jump_target = i_entry.alu_result;

endmodule

// ==== source/ex_mem_reg.sv ====
// EX/MEM pipeline register; loads one entry per edge and holds it while the pipeline stalls
`timescale 1ns/1ps

module ex_mem_reg
(
    input  logic               i_clk,
    input  logic               i_reset,          // Synchronous, active high
    input  logic               i_stall,          // Level; high holds the entry
    input  exmem_pkg::ex_mem_t i_entry,          // From execute stage
    output exmem_pkg::ex_mem_t o_entry           // To memory stage
);

    exmem_pkg::ex_mem_t entry_q;

    // A cleared entry is a bubble: no register write, no store, no jump
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            entry_q <= '0;
        end
        else if (!i_stall)
        begin
            entry_q <= i_entry;
        end
    end

    assign o_entry = entry_q;

endmodule

// ==== source/execute_stage.sv ====
// Execute stage ALU; combines the ID/EX values into one EX/MEM entry in zero cycles
`timescale 1ns/1ps

module execute_stage
(
    input  exmem_pkg::ex_ctrl_t  i_ctrl,         // Control lines from decode
    input  exmem_pkg::alu_op_t   i_alu_op,
    input  exmem_pkg::word_t     i_operand_a,    // Shift amount for shifts
    input  exmem_pkg::word_t     i_operand_b,
    input  exmem_pkg::word_t     i_store_data,
    input  exmem_pkg::reg_addr_t i_dest_reg,
    input  exmem_pkg::word_t     i_link_addr,
    output exmem_pkg::ex_mem_t   o_entry         // To the EX/MEM register
);

    exmem_pkg::word_t alu_result;
    logic [4:0]       shamt;
    logic             signed_lt;
    logic             unsigned_lt;

    assign shamt       = i_operand_a[4:0];      // Only the low 5 bits shift
    assign signed_lt   = $signed(i_operand_a) < $signed(i_operand_b);
    assign unsigned_lt = i_operand_a < i_operand_b;

    always_comb
    begin
        case (i_alu_op)
            exmem_pkg::ALU_ADD:
            begin
                alu_result = i_operand_a + i_operand_b;
            end
            exmem_pkg::ALU_SUB:
            begin
                alu_result = i_operand_a - i_operand_b;
            end
            exmem_pkg::ALU_AND:
            begin
                alu_result = i_operand_a & i_operand_b;
            end
            exmem_pkg::ALU_OR:
            begin
                alu_result = i_operand_a | i_operand_b;
            end
            exmem_pkg::ALU_XOR:
            begin
                alu_result = i_operand_a ^ i_operand_b;
            end
            exmem_pkg::ALU_NOR:
            begin
                alu_result = ~(i_operand_a | i_operand_b);
            end
            exmem_pkg::ALU_SLT:
            begin
                alu_result = {31'd0, signed_lt};
            end
            exmem_pkg::ALU_SLTU:
            begin
                alu_result = {31'd0, unsigned_lt};
            end
            exmem_pkg::ALU_SLL:
            begin
                alu_result = i_operand_b << shamt;
            end
            exmem_pkg::ALU_SRL:
            begin
                alu_result = i_operand_b >> shamt;
            end
            exmem_pkg::ALU_SRA:
            begin
                alu_result = $signed(i_operand_b) >>> shamt;   // Sign fill
            end
            exmem_pkg::ALU_LUI:
            begin
                alu_result = {i_operand_b[15:0], 16'd0};
            end
            exmem_pkg::ALU_PASS_A:
            begin
                alu_result = i_operand_a;                      // Register jump target
            end
            default:
            begin
                alu_result = '0;
            end
        endcase
    end

    // Everything the memory stage needs rides in one entry
    assign o_entry.ctrl       = i_ctrl;
    assign o_entry.alu_result = alu_result;
    assign o_entry.store_data = i_store_data;
    assign o_entry.dest_reg   = i_dest_reg;
    assign o_entry.link_addr  = i_link_addr;

endmodule

// ==== source/exmem_pkg.sv ====
// Shared widths, ALU operation codes and EX/MEM entry types for the execute-to-memory slice
package exmem_pkg;

    localparam int WORD_W      = 32;             // Datapath width
    localparam int REG_ADDR_W  = 5;              // Register file index
    localparam int ALU_OP_W    = 4;
    localparam int DMEM_DEPTH  = 64;             // Data memory words
    localparam int DMEM_ADDR_W = 6;              // Word address into data memory

    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [DMEM_ADDR_W-1:0] dmem_addr_t;

    // ALU operation select; codes 13..15 are unused and give zero
    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_NOR    = 4'd5,
        ALU_SLT    = 4'd6,               // Signed compare
        ALU_SLTU   = 4'd7,               // Unsigned compare
        ALU_SLL    = 4'd8,
        ALU_SRL    = 4'd9,
        ALU_SRA    = 4'd10,
        ALU_LUI    = 4'd11,
        ALU_PASS_A = 4'd12               // Register jump target
    } alu_op_t;

    typedef struct packed {
        logic mem_read;
        logic mem_write;
        logic reg_write;
        logic mem_to_reg;
        logic link_sel;                  // Write back the link address
        logic jump;
    } ex_ctrl_t;

    typedef struct packed {
        ex_ctrl_t  ctrl;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dest_reg;
        word_t     link_addr;            // Return address saved by jump-and-link
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t dest_reg;
        word_t     data;
    } wb_t;

endpackage
